/* filelist.f */
fir_regmap_pkg.sv
fir_stream_pkg.sv
fir_lite_regs.sv
fir_ctrl.sv
fir_sample_buffer.sv
fir_mac.sv
fir_top.sv
fir_sva.sv
tb_fir.sv

/* fir_ctrl.sv */
`default_nettype none

module fir_ctrl (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  fir_regmap_pkg::ctrl_cmd_t         cmd,
    output fir_regmap_pkg::ctrl_status_t      status,
    input  logic [fir_regmap_pkg::DATA_W-1:0] data_length,
    input  logic                              ss_tvalid,
    output logic                              ss_tready,
    output logic                              sample_take,
    output logic                              buffer_clear,
    input  logic                              mac_busy,
    input  logic                              sm_tvalid,
    input  logic                              sm_tready,
    output logic                              sm_tlast
);
    import fir_regmap_pkg::*;
    import fir_stream_pkg::*;

    run_state_e        state;
    run_state_e        state_next;
    logic [DATA_W-1:0] out_cnt;
    logic              done_q;
    logic              start_ok;
    logic              out_hs;
    logic              last_out;

    // Start is only honoured between runs
    assign start_ok = cmd.start && (state == RUN_IDLE);
    assign out_hs   = sm_tvalid && sm_tready;
    assign last_out = (out_cnt == data_length - 1'b1);

    // ------------------------------
    // Stream gating
    // ------------------------------
    // One sample in flight, so hold input off until the MAC is free again
    assign ss_tready    = ((state == RUN_ARMED) || (state == RUN_ACTIVE)) && !mac_busy;
    assign sample_take  = ss_tvalid && ss_tready;
    assign buffer_clear = start_ok;
    assign sm_tlast     = sm_tvalid && (state == RUN_ACTIVE) && last_out;

    // Status readback
    assign status.start = (state == RUN_ARMED);
    assign status.done  = done_q;
    assign status.idle  = (state == RUN_IDLE);

    // ------------------------------
    // Run FSM
    // ------------------------------
    always_comb begin
        state_next = state;
        unique case (state)
            RUN_IDLE: begin
                if (start_ok) begin
                    state_next = RUN_ARMED;
                end
            end
            RUN_ARMED: begin
                if (sample_take) begin
                    state_next = RUN_ACTIVE;
                end
            end
            RUN_ACTIVE: begin
                if (out_hs && sm_tlast) begin
                    state_next = RUN_IDLE;
                end
            end
            default: state_next = RUN_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state   <= RUN_IDLE;
            out_cnt <= '0;
            done_q  <= 1'b0;
        end else begin
            state <= state_next;
            // Output count restarts with each run
            if (start_ok) begin
                out_cnt <= '0;
            end else if (out_hs) begin
                out_cnt <= out_cnt + 1'b1;
            end
            if (out_hs && sm_tlast) begin
                done_q <= 1'b1;
            end else if (start_ok || cmd.done_clear) begin
                done_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* fir_lite_regs.sv */
`default_nettype none

module fir_lite_regs (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic [fir_regmap_pkg::ADDR_W-1:0] awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [fir_regmap_pkg::DATA_W-1:0] wdata,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [fir_regmap_pkg::ADDR_W-1:0] araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [fir_regmap_pkg::DATA_W-1:0] rdata,
    output logic                              rvalid,
    input  logic                              rready,
    output fir_regmap_pkg::ctrl_cmd_t         cmd,
    input  fir_regmap_pkg::ctrl_status_t      status,
    output fir_stream_pkg::tap_bank_t         coefs,
    output logic [fir_regmap_pkg::DATA_W-1:0] data_length
);
    import fir_regmap_pkg::*;
    import fir_stream_pkg::*;

    logic              aw_held;
    logic              w_held;
    logic [ADDR_W-1:0] waddr_q;
    logic [DATA_W-1:0] wdata_q;
    logic              write_commit;
    logic              rd_config_q;
    logic [DATA_W-1:0] rd_next;

    // Word-aligned address inside the coefficient window
    function automatic logic tap_hit(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] offset;
        offset = addr - ADDR_TAP_BASE;
        return (addr >= ADDR_TAP_BASE) && (offset[1:0] == 2'b00) &&
               (offset[ADDR_W-1:2] < NUM_TAPS);
    endfunction

    function automatic logic [TAP_IDX_W-1:0] tap_index(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] offset;
        offset = addr - ADDR_TAP_BASE;
        return offset[TAP_IDX_W+1:2];
    endfunction

    // ------------------------------
    // Write channel
    // ------------------------------
    assign awready      = !aw_held;
    assign wready       = !w_held;
    assign write_commit = aw_held && w_held;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end else if (write_commit) begin
                aw_held <= 1'b0;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end else if (write_commit) begin
                w_held <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (awvalid && awready) begin
            waddr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_length <= '0;
        end else if (write_commit && (waddr_q == ADDR_LENGTH)) begin
            data_length <= wdata_q;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (write_commit && tap_hit(waddr_q)) begin
            coefs[tap_index(waddr_q)] <= wdata_q;
        end
    end

    // Status bits live in the run control and only strobes go out
    assign cmd.start      = write_commit && (waddr_q == ADDR_CONFIG) && wdata_q[CFG_START_BIT];
    assign cmd.done_clear = rvalid && rready && rd_config_q && rdata[CFG_DONE_BIT];

    // ------------------------------
    // Read channel
    // ------------------------------
    // No new read while a write commits
    assign arready = !rvalid && !write_commit;

    always_comb begin
        rd_next = '0;
        if (araddr == ADDR_CONFIG) begin
            rd_next[CFG_START_BIT] = status.start;
            rd_next[CFG_DONE_BIT]  = status.done;
            rd_next[CFG_IDLE_BIT]  = status.idle;
        end else if (araddr == ADDR_LENGTH) begin
            rd_next = data_length;
        end else if (tap_hit(araddr)) begin
            rd_next = coefs[tap_index(araddr)];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rvalid      <= 1'b0;
            rd_config_q <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid      <= 1'b1;
            rd_config_q <= (araddr == ADDR_CONFIG);
        end else if (rvalid && rready) begin
            rvalid      <= 1'b0;
            rd_config_q <= 1'b0;
        end
    end

    // Snapshot at the address handshake holds until rready
    always_ff @(posedge axis_clk) begin
        if (arvalid && arready) begin
            rdata <= rd_next;
        end
    end

endmodule

`default_nettype wire

/* fir_mac.sv */
`default_nettype none

module fir_mac (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  logic                      start,
    input  fir_stream_pkg::tap_bank_t coefs,
    input  fir_stream_pkg::tap_bank_t window,
    output logic                      busy,
    output logic                      sm_tvalid,
    output fir_stream_pkg::sample_t   sm_tdata,
    input  logic                      sm_tready
);
    import fir_stream_pkg::*;

    mac_state_e           state;
    logic [TAP_IDX_W-1:0] tap_idx;
    sample_t              prod_q;
    logic                 prod_valid;
    sample_t              acc;

    // Busy from start until the result is taken
    assign busy     = (state != MAC_IDLE);
    assign sm_tdata = acc;

    // Product stage handles one tap per cycle and wraps to 32 bits
    always_ff @(posedge axis_clk) begin
        prod_q <= coefs[tap_idx] * window[tap_idx];
    end

    // ------------------------------
    // Tap sequencing and accumulate
    // ------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state      <= MAC_IDLE;
            tap_idx    <= '0;
            prod_valid <= 1'b0;
            acc        <= '0;
            sm_tvalid  <= 1'b0;
        end else begin
            prod_valid <= (state == MAC_BUSY);
            if (prod_valid) begin
                acc <= acc + prod_q;
            end
            unique case (state)
                MAC_IDLE: begin
                    if (start) begin
                        state   <= MAC_BUSY;
                        tap_idx <= '0;
                    end
                end
                MAC_BUSY: begin
                    if (tap_idx == TAP_IDX_W'(NUM_TAPS - 1)) begin
                        state <= MAC_HOLD;
                    end else begin
                        tap_idx <= tap_idx + 1'b1;
                    end
                end
                MAC_HOLD: begin
                    // Last product lands first, then the sum is offered
                    if (prod_valid) begin
                        sm_tvalid <= 1'b1;
                    end else if (sm_tvalid && sm_tready) begin
                        sm_tvalid <= 1'b0;
                        acc       <= '0;
                        state     <= MAC_IDLE;
                    end
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* fir_regmap_pkg.sv */
`default_nettype none

package fir_regmap_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    // ------------------------------
    // Address map
    // ------------------------------
    localparam logic [ADDR_W-1:0] ADDR_CONFIG   = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_LENGTH   = 12'h010;
    // Coefficient i at ADDR_TAP_BASE + 4*i
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h020;

    // Config register bit positions
    localparam int CFG_START_BIT = 0;
    localparam int CFG_DONE_BIT  = 1;
    localparam int CFG_IDLE_BIT  = 2;

    // Strobes from the register block into the run control
    typedef struct packed {
        logic start;
        logic done_clear;
    } ctrl_cmd_t;

    // Status bits returned on config reads
    typedef struct packed {
        logic start;
        logic done;
        logic idle;
    } ctrl_status_t;

endpackage

`default_nettype wire

/* fir_sample_buffer.sv */
`default_nettype none

module fir_sample_buffer (
    input  logic                      axis_clk,
    input  logic                      axis_rst_n,
    input  logic                      clear,
    input  logic                      shift,
    input  fir_stream_pkg::sample_t   sample_in,
    output fir_stream_pkg::tap_bank_t window
);
    import fir_stream_pkg::*;

    // ------------------------------
    // Sample history
    // ------------------------------
    // Entry 0 is the newest sample, entry NUM_TAPS-1 the oldest
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            window <= '0;
        end else if (clear) begin
            // Fresh run starts from zero history
            window <= '0;
        end else if (shift) begin
            window <= {window[NUM_TAPS-2:0], sample_in};
        end
    end

endmodule

`default_nettype wire

/* fir_stream_pkg.sv */
`default_nettype none

package fir_stream_pkg;

    // ------------------------------
    // Filter geometry
    // ------------------------------
    localparam int NUM_TAPS  = 11;
    localparam int TAP_IDX_W = 4;

    // Samples, coefficients and the accumulator all wrap at 32 bits
    typedef logic signed [31:0] sample_t;

    // Entry 0 holds coefficient 0 or the newest sample
    typedef sample_t [NUM_TAPS-1:0] tap_bank_t;

    // ------------------------------
    // FSM encodings
    // ------------------------------
    typedef enum logic [1:0] {
        RUN_IDLE   = 2'd0,
        RUN_ARMED  = 2'd1,
        RUN_ACTIVE = 2'd2
    } run_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE = 2'd0,
        MAC_BUSY = 2'd1,
        MAC_HOLD = 2'd2
    } mac_state_e;

endpackage

`default_nettype wire

/* fir_sva.sv */
`default_nettype none

module fir_sva (
    input logic                              axis_clk,
    input logic                              axis_rst_n,
    input logic                              sm_tvalid,
    input logic                              sm_tready,
    input logic                              sm_tlast,
    input logic [fir_regmap_pkg::DATA_W-1:0] sm_tdata,
    input logic                              ss_tready,
    input logic                              rvalid,
    input logic                              rready,
    input logic [fir_regmap_pkg::DATA_W-1:0] rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // ------------------------------
    // Output stream
    // ------------------------------
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else begin
            fail_count++;
            $error("sm_tvalid or sm_tdata changed before sm_tready");
        end

    // One sample in flight
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> !ss_tready)
        else begin
            fail_count++;
            $error("ss_tready high while a result is pending");
        end

    // Last flag belongs to the pending result
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> $stable(sm_tlast))
        else begin
            fail_count++;
            $error("sm_tlast changed before sm_tready");
        end

    // ------------------------------
    // Read data channel
    // ------------------------------
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            fail_count++;
            $error("rvalid or rdata changed before rready");
        end

endmodule

bind fir_top fir_sva u_sva (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata),
    .ss_tready  (ss_tready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata)
);

`default_nettype wire

/* fir_top.sv */
`default_nettype none

module fir_top (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    // AXI4-Lite register port
    input  logic [fir_regmap_pkg::ADDR_W-1:0] awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [fir_regmap_pkg::DATA_W-1:0] wdata,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [fir_regmap_pkg::ADDR_W-1:0] araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [fir_regmap_pkg::DATA_W-1:0] rdata,
    output logic                              rvalid,
    input  logic                              rready,
    // Sample input stream
    input  logic [fir_regmap_pkg::DATA_W-1:0] ss_tdata,
    // Run length comes from data_length, so ss_tlast has no effect
    input  logic                              ss_tlast,
    input  logic                              ss_tvalid,
    output logic                              ss_tready,
    // Result output stream
    output logic [fir_regmap_pkg::DATA_W-1:0] sm_tdata,
    output logic                              sm_tlast,
    output logic                              sm_tvalid,
    input  logic                              sm_tready
);
    import fir_regmap_pkg::*;
    import fir_stream_pkg::*;

    ctrl_cmd_t         cmd;
    ctrl_status_t      status;
    tap_bank_t         coefs;
    tap_bank_t         window;
    logic [DATA_W-1:0] data_length;
    logic              sample_take;
    logic              buffer_clear;
    logic              mac_busy;

    fir_lite_regs u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .cmd         (cmd),
        .status      (status),
        .coefs       (coefs),
        .data_length (data_length)
    );

    fir_ctrl u_ctrl (
        .axis_clk     (axis_clk),
        .axis_rst_n   (axis_rst_n),
        .cmd          (cmd),
        .status       (status),
        .data_length  (data_length),
        .ss_tvalid    (ss_tvalid),
        .ss_tready    (ss_tready),
        .sample_take  (sample_take),
        .buffer_clear (buffer_clear),
        .mac_busy     (mac_busy),
        .sm_tvalid    (sm_tvalid),
        .sm_tready    (sm_tready),
        .sm_tlast     (sm_tlast)
    );

    fir_sample_buffer u_buffer (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .clear      (buffer_clear),
        .shift      (sample_take),
        .sample_in  (ss_tdata),
        .window     (window)
    );

    fir_mac u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (sample_take),
        .coefs      (coefs),
        .window     (window),
        .busy       (mac_busy),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tready  (sm_tready)
    );

endmodule

`default_nettype wire

/* fir_vectors.txt */
// Per run: 11 coefficients, data length, input samples, expected outputs
// One 32-bit hex word per line, runs back to back
// Run 1: symmetric low-pass taps, ramp input, length 8
00000000 FFFFFFF6 FFFFFFF7 00000017 00000038 0000003F
00000038 00000017 FFFFFFF7 FFFFFFF6 00000000
00000008
00000001 00000002 00000003 00000004
00000005 00000006 00000007 00000008
00000000 FFFFFFF6 FFFFFFE3 FFFFFFE7
00000023 0000009E 00000151 0000021B
// Run 2: taps 1 to 11, mixed sign input, length 6
00000001 00000002 00000003 00000004 00000005 00000006
00000007 00000008 00000009 0000000A 0000000B
00000006
00000005 FFFFFFFD 00000007 00000002 FFFFFFFF 00000004
00000005 00000007 00000010 0000001B 00000025 00000033

/* tb_fir.sv */
`default_nettype none

module tb_fir;
    timeunit 1ns;
    timeprecision 1ps;
    import fir_regmap_pkg::*;
    import fir_stream_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int MAX_GAP       = 3;
    localparam int MAX_STALL     = 4;
    localparam int NUM_WORDS     = 52;
    localparam int TOTAL_SAMPLES = 14;
    // Per run 12 writes, 12 readbacks, start write and read, two done reads
    localparam int NUM_ACCESSES  = 2 * 28 + 2;
    localparam int WATCHDOG_CYCLES =
        (TOTAL_SAMPLES * (NUM_TAPS + 1 + MAX_STALL + MAX_GAP) + 64 * NUM_ACCESSES + 10) * 2;

    logic              axis_clk;
    logic              axis_rst_n;
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;
    logic              rready;
    logic [DATA_W-1:0] ss_tdata;
    logic              ss_tlast;
    logic              ss_tvalid;
    logic              ss_tready;
    logic [DATA_W-1:0] sm_tdata;
    logic              sm_tlast;
    logic              sm_tvalid;
    logic              sm_tready;

    logic [DATA_W-1:0] vectors [0:NUM_WORDS-1];
    int                errors;
    int                test_mark;
    int                tests_run;
    int                tests_failed;

    fir_top dut (.*);

    always #(CLK_PERIOD / 2) axis_clk = ~axis_clk;

    // ------------------------------
    // Reporting
    // ------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_mark) begin
            tests_failed++;
            $display("[FAIL] %s (%0d errors)", name, errors - test_mark);
        end else begin
            $display("[PASS] %s", name);
        end
        test_mark = errors;
    endtask

    // ------------------------------
    // AXI4-Lite access
    // ------------------------------
    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic aw_hs;
        logic w_hs;
        @(negedge axis_clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        // Address and data may be taken on different edges
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge axis_clk);
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge axis_clk);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    // ------------------------------
    // Streams
    // ------------------------------
    task automatic feed_samples(input int first, input int len);
        int k;
        int gap;
        @(negedge axis_clk);
        for (k = 0; k < len; k++) begin
            gap = $urandom_range(MAX_GAP);
            repeat (gap) @(negedge axis_clk);
            ss_tdata  = vectors[first + k];
            ss_tlast  = (k == len - 1);
            ss_tvalid = 1'b1;
            while (!ss_tready) @(negedge axis_clk);
            @(negedge axis_clk);
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
    endtask

    task automatic collect_results(input int run_no, input int first, input int len);
        int k;
        int stall;
        for (k = 0; k < len; k++) begin
            stall = $urandom_range(MAX_STALL);
            @(negedge axis_clk);
            sm_tready = 1'b0;
            while (!sm_tvalid) @(negedge axis_clk);
            // Hold the result back for a few cycles
            repeat (stall) @(negedge axis_clk);
            sm_tready = 1'b1;
            if (sm_tdata !== vectors[first + k]) begin
                report_mismatch($sformatf("filter_run%0d out %0d", run_no, k),
                                vectors[first + k], sm_tdata);
            end
            if (sm_tlast !== (k == len - 1)) begin
                report_mismatch($sformatf("filter_run%0d tlast %0d", run_no, k),
                                32'(k == len - 1), 32'(sm_tlast));
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    task automatic check_reset();
        logic [DATA_W-1:0] rd;
        read_reg(ADDR_CONFIG, rd);
        if (rd !== 32'h4) report_mismatch("reset config", 32'h4, rd);
        read_reg(12'h00C, rd);
        if (rd !== 32'h0) report_mismatch("reset unmapped 0x0C", 32'h0, rd);
        finish_test("reset");
    endtask

    task automatic run_filter(input int run_no, input int base);
        int                len;
        int                i;
        logic [DATA_W-1:0] rd;
        len = int'(vectors[base + NUM_TAPS]);
        for (i = 0; i < NUM_TAPS; i++) begin
            write_reg(ADDR_TAP_BASE + ADDR_W'(4 * i), vectors[base + i]);
        end
        write_reg(ADDR_LENGTH, vectors[base + NUM_TAPS]);
        for (i = 0; i < NUM_TAPS; i++) begin
            read_reg(ADDR_TAP_BASE + ADDR_W'(4 * i), rd);
            if (rd !== vectors[base + i]) begin
                report_mismatch($sformatf("regs_run%0d coef %0d", run_no, i),
                                vectors[base + i], rd);
            end
        end
        read_reg(ADDR_LENGTH, rd);
        if (rd !== vectors[base + NUM_TAPS]) begin
            report_mismatch($sformatf("regs_run%0d length", run_no), vectors[base + NUM_TAPS], rd);
        end
        finish_test($sformatf("regs_run%0d", run_no));
        // Armed but no sample yet, so start=1 and idle=0
        write_reg(ADDR_CONFIG, 32'h1);
        read_reg(ADDR_CONFIG, rd);
        if (rd !== 32'h1) report_mismatch($sformatf("start_run%0d config", run_no), 32'h1, rd);
        finish_test($sformatf("start_run%0d", run_no));
        fork
            feed_samples(base + NUM_TAPS + 1, len);
            collect_results(run_no, base + NUM_TAPS + 1 + len, len);
        join
        finish_test($sformatf("filter_run%0d", run_no));
        read_reg(ADDR_CONFIG, rd);
        if (rd !== 32'h6) report_mismatch($sformatf("done_run%0d first read", run_no), 32'h6, rd);
        read_reg(ADDR_CONFIG, rd);
        if (rd !== 32'h4) report_mismatch($sformatf("done_run%0d second read", run_no), 32'h4, rd);
        finish_test($sformatf("done_run%0d", run_no));
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        axis_clk     = 1'b0;
        axis_rst_n   = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wvalid       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        ss_tdata     = '0;
        ss_tlast     = 1'b0;
        ss_tvalid    = 1'b0;
        sm_tready    = 1'b0;
        errors       = 0;
        test_mark    = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h3ba6));
        $readmemh("fir_vectors.txt", vectors);
        repeat (10) @(negedge axis_clk);
        axis_rst_n = 1'b1;
        if ($isunknown(vectors[NUM_WORDS-1])) begin
            $display("The vector file fir_vectors.txt could not be read completely");
            errors++;
        end else begin
            check_reset();
            run_filter(1, 0);
            run_filter(2, 28);
        end
        if (dut.u_sva.fail_count != 0) begin
            $display("Bound assertions failed %0d times", dut.u_sva.fail_count);
            errors++;
        end
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from sample count, stalls and register accesses
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
